// File: d_cache.f
+incdir+include
rtl/d_cache_pkg.sv
rtl/d_cache_lookup.sv
rtl/d_cache_way.sv
rtl/d_cache_ctrl.sv
rtl/d_cache.sv
dv/tb_clk_gen.sv
dv/d_cache_checker.sv
dv/d_cache_tb.sv

// File: dv/d_cache_trace.txt
# op(L/S) addr wdata wstrb exp_rdata exp_writeback_line (hex, none = no write-back)
# memory starts as byte address ^ a5a50000 over 256 words, so 0x400 aliases 0x000
L 00000004 00000000 0 a5a50004 none
L 00000004 00000000 0 a5a50004 none
L 00000058 00000000 0 a5a50058 none
S 00000008 11223344 5 a5220044 none
L 00000008 00000000 0 a5220044 none
S 00000074 deadbeef c dead0074 none
L 00000074 00000000 0 dead0074 none
L 00000020 00000000 0 a5a50020 none
S 00000124 cafef00d f cafef00d none
L 00000228 00000000 0 a5a50228 none
L 0000032c 00000000 0 a5a5032c none
L 00000020 00000000 0 a5a50020 none
L 00000424 00000000 0 a5a50024 00000120
L 00000124 00000000 0 cafef00d none
L 00000100 00000000 0 a5a50100 none
L 00000200 00000000 0 a5a50200 none
L 0000030c 00000000 0 a5a5030c none
S 00000208 0000ab00 2 a5a5ab08 none
L 00000404 00000000 0 a5a50004 none
L 00000500 00000000 0 a5a50100 00000000
L 00000008 00000000 0 a5220044 none
L 00000900 00000000 0 a5a50100 00000200
L 00000208 00000000 0 a5a5ab08 none

// File: dv/d_cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module d_cache_tb;

    logic        clk;
    logic        rst;
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        done;
    logic [31:0] rdata;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] mem_rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] mem_wdata;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    logic [31:0] exp_rdata;
    logic        exp_wb;
    logic [31:0] exp_wb_addr;
    int          data_errs;
    int          wb_errs;
    int          bus_errs;

    // trace columns, one entry per request
    logic        t_we [$];
    logic [31:0] t_addr [$];
    logic [31:0] t_wdata [$];
    logic [3:0]  t_wstrb [$];
    logic [31:0] t_rdata [$];
    logic        t_wb [$];
    logic [31:0] t_wb_addr [$];

    logic [31:0] mem [256];
    logic [15:0] lfsr;
    int          limit;

    tb_clk_gen i_clk_gen (.clk, .rst);

    d_cache i_dut (.*);

    d_cache_checker i_checker (.*);

    // taps for x^16 + x^14 + x^13 + x^11
    function automatic int lfsr_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = (v << 1) | fb;
        end
        return v;
    endfunction

    task automatic read_trace();
        int          fd;
        int          cnt;
        string       line;
        string       op;
        string       wb_str;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  s;
        logic [31:0] r;
        logic [31:0] wb;
        fd = $fopen("dv/d_cache_trace.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%s %h %h %h %h %s", op, a, d, s, r, wb_str);
                    if (cnt == 6) begin
                        wb = '0;
                        if (wb_str != "none") begin
                            cnt = $sscanf(wb_str, "%h", wb);
                        end
                        t_we.push_back(op == "S");
                        t_addr.push_back(a);
                        t_wdata.push_back(d);
                        t_wstrb.push_back(s);
                        t_rdata.push_back(r);
                        t_wb.push_back(wb_str != "none");
                        t_wb_addr.push_back(wb);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // starts just after an edge, ends on the edge that sees done
    task automatic run_request(input int i);
        #1;
        req         = 1'b1;
        we          = t_we[i];
        addr        = t_addr[i];
        wdata       = t_wdata[i];
        wstrb       = t_wstrb[i];
        exp_rdata   = t_rdata[i];
        exp_wb      = t_wb[i];
        exp_wb_addr = t_wb_addr[i];
        @(posedge clk);
        while (done !== 1'b1) @(posedge clk);
    endtask

    task automatic print_counts(input int timeouts);
        $display("summary: %0d rdata errors, %0d write-back errors, %0d bus errors, %0d timeouts",
                 data_errs, wb_errs, bus_errs, timeouts);
    endtask

    initial begin
        lfsr = 16'd58568;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i << 2) ^ 32'hA5A5_0000;   // byte address of the word
        end
    end

    initial begin : read_port
        logic [7:0] base;
        int         gap;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (arvalid === 1'b1) begin
                repeat (lfsr_bits(2)) @(posedge clk);
                #1 arready = 1'b1;
                @(posedge clk);           // arvalid still high, so accepted here
                base = araddr[9:2];
                #1 arready = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    gap = lfsr_bits(2);
                    if (gap != 0) begin
                        rvalid = 1'b0;
                        rlast  = 1'b0;
                        repeat (gap) @(posedge clk);
                        #1;
                    end
                    rvalid    = 1'b1;
                    rlast     = (b == 3);
                    mem_rdata = mem[base + b];
                    @(posedge clk);
                    while (rready !== 1'b1) @(posedge clk);
                    #1;
                end
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

    initial begin : write_port
        logic [7:0] base;
        int         gap;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(posedge clk);
            if (awvalid === 1'b1) begin
                repeat (lfsr_bits(2)) @(posedge clk);
                #1 awready = 1'b1;
                @(posedge clk);
                base = awaddr[9:2];
                #1 awready = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    gap = lfsr_bits(2);
                    if (gap != 0) begin
                        wready = 1'b0;
                        repeat (gap) @(posedge clk);
                        #1;
                    end
                    wready = 1'b1;
                    @(posedge clk);
                    while (wvalid !== 1'b1) @(posedge clk);
                    mem[base + b] = mem_wdata;
                    #1;
                end
                wready = 1'b0;
                gap    = lfsr_bits(2);
                if (gap != 0) begin
                    repeat (gap) @(posedge clk);
                    #1;
                end
                bvalid = 1'b1;
                @(posedge clk);
                while (bready !== 1'b1) @(posedge clk);
                #1 bvalid = 1'b0;
            end
        end
    end

    initial begin : driver
        int total;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        wstrb       = '0;
        exp_rdata   = '0;
        exp_wb      = 1'b0;
        exp_wb_addr = '0;
        read_trace();
        limit = 200 * t_addr.size() + 100;
        if (t_addr.size() == 0) begin
            $display("trace dv/d_cache_trace.txt could not be read or holds no requests");
            $display("** FAIL **");
            $finish;
        end else begin
            while (rst !== 1'b0) @(posedge clk);
            for (int i = 0; i < t_addr.size(); i++) begin
                run_request(i);
            end
            #1 req = 1'b0;
            total = data_errs + wb_errs + bus_errs;
            print_counts(0);
            if (total == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: trace still running after %0d cycles", cycles);
        print_counts(1);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/d_cache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module d_cache_checker (
    input  wire        clk,
    input  wire        rst,
    input  wire        done,
    input  wire [31:0] rdata,
    input  wire [31:0] addr,
    input  wire        arvalid,
    input  wire        arready,
    input  wire [31:0] araddr,
    input  wire        awvalid,
    input  wire        awready,
    input  wire [31:0] awaddr,
    input  wire        wvalid,
    input  wire        wready,
    input  wire        wlast,
    input  wire [31:0] exp_rdata,
    input  wire        exp_wb,
    input  wire [31:0] exp_wb_addr,
    output int         data_errs,
    output int         wb_errs,
    output int         bus_errs
);

    int          req_num;
    int          w_beat;        // beat number inside the current write burst
    logic        wb_seen;      // aw handshake seen during the current request
    logic [31:0] exp_araddr;

    assign exp_araddr = {addr[31:4], 4'h0};   // line holding the requested word

    initial begin
        data_errs = 0;
        wb_errs   = 0;
        bus_errs  = 0;
        req_num   = 0;
        w_beat    = 0;
        wb_seen   = 1'b0;
    end

    always @(posedge clk) begin
        if (rst === 1'b0) begin
            if (arvalid === 1'b1 && arready === 1'b1) begin
                if (araddr !== exp_araddr) begin
                    $display("[FAIL] araddr expected 0x%08h actual 0x%08h (request %0d)",
                             exp_araddr, araddr, req_num);
                    bus_errs++;
                end
            end
            if (awvalid === 1'b1 && awready === 1'b1) begin
                if (!exp_wb) begin
                    $display("request %0d: write-back to 0x%08h although the victim is clean",
                             req_num, awaddr);
                    wb_errs++;
                end else if (awaddr !== exp_wb_addr) begin
                    $display("[FAIL] awaddr expected 0x%08h actual 0x%08h (request %0d)",
                             exp_wb_addr, awaddr, req_num);
                    wb_errs++;
                end
                wb_seen = 1'b1;
            end
            if (wvalid === 1'b1 && wready === 1'b1) begin
                if (wlast !== (w_beat == 3)) begin
                    $display("[FAIL] wlast expected 0x%0h actual 0x%0h (request %0d)",
                             (w_beat == 3), wlast, req_num);
                    bus_errs++;
                end
                w_beat = (w_beat + 1) % 4;
            end
            if (done === 1'b1) begin
                if (rdata !== exp_rdata) begin
                    $display("[FAIL] rdata expected 0x%08h actual 0x%08h (request %0d)",
                             exp_rdata, rdata, req_num);
                    data_errs++;
                end
                if (exp_wb && !wb_seen) begin
                    $display("request %0d: expected write-back to 0x%08h never happened",
                             req_num, exp_wb_addr);
                    wb_errs++;
                end
                wb_seen = 1'b0;
                req_num++;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: rtl/d_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_cache_cfg.svh"

module d_cache import d_cache_pkg::*; (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req,
    input  wire                      we,
    input  wire [`DC_ADDR_BITS-1:0]  addr,
    input  wire word_t               wdata,
    input  wire strb_t               wstrb,
    output logic                     done,
    output word_t                    rdata,
    output logic [`DC_ADDR_BITS-1:0] araddr,
    output logic                     arvalid,
    input  wire                      arready,
    input  wire word_t               mem_rdata,
    input  wire                      rlast,
    input  wire                      rvalid,
    output logic                     rready,
    output logic [`DC_ADDR_BITS-1:0] awaddr,
    output logic                     awvalid,
    input  wire                      awready,
    output word_t                    mem_wdata,
    output logic                     wlast,
    output logic                     wvalid,
    input  wire                      wready,
    input  wire                      bvalid,
    output logic                     bready
);

    logic      busy;
    index_t    rd_index;
    tag_t      req_tag;
    offset_t   req_offset;
    logic      req_we;
    word_t     req_wdata;
    strb_t     req_wstrb;
    way_mask_t wr_en;
    index_t    wr_index;
    offset_t   wr_offset;
    word_t     wr_data;
    strb_t     wr_bstrb;
    logic      tag_wr;
    logic      dirty_in;
    logic      accept;
    logic      fill_beat;
    offset_t   fill_offset;
    word_t     fill_data;
    way_t      fill_way;
    logic      store_hit;
    way_t      store_hit_way;
    way_mask_t hit_bits;
    way_mask_t vic_dirty_bits;
    tag_t      vic_tag [`DC_WAYS];
    word_t     line_word [`DC_WAYS][1 << `DC_WORD_BITS];

    d_cache_lookup i_lookup (.*);

    for (genvar g = 0; g < `DC_WAYS; g++) begin : g_way
        d_cache_way i_way (
            .clk,
            .rst,
            .rd_index,
            .req_tag,
            .wr_en      (wr_en[g]),
            .wr_index,
            .wr_offset,
            .wr_data,
            .wr_bstrb,
            .tag_wr,
            .dirty_in,
            .hit_bit    (hit_bits[g]),
            .vic_dirty  (vic_dirty_bits[g]),
            .vic_tag    (vic_tag[g]),
            .line_word0 (line_word[g][0]),
            .line_word1 (line_word[g][1]),
            .line_word2 (line_word[g][2]),
            .line_word3 (line_word[g][3])
        );
    end

    d_cache_ctrl i_ctrl (.*);

endmodule

`default_nettype wire

// File: rtl/d_cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_cache_cfg.svh"

module d_cache_ctrl import d_cache_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     busy,
    input  wire                     req_we,
    input  wire tag_t               req_tag,
    input  wire offset_t            req_offset,
    input  wire word_t              req_wdata,
    input  wire strb_t              req_wstrb,
    input  wire way_mask_t          hit_bits,
    input  wire way_mask_t          vic_dirty_bits,
    input  wire tag_t               vic_tag [`DC_WAYS],
    input  wire word_t              line_word [`DC_WAYS][1 << `DC_WORD_BITS],
    input  wire index_t             rd_index,
    output logic                    done,
    output word_t                   rdata,
    output logic [`DC_ADDR_BITS-1:0] araddr,
    output logic                    arvalid,
    input  wire                     arready,
    input  wire word_t              mem_rdata,
    input  wire                     rlast,
    input  wire                     rvalid,
    output logic                    rready,
    output logic [`DC_ADDR_BITS-1:0] awaddr,
    output logic                    awvalid,
    input  wire                     awready,
    output word_t                   mem_wdata,
    output logic                    wlast,
    output logic                    wvalid,
    input  wire                     wready,
    input  wire                     bvalid,
    output logic                    bready,
    output logic                    accept,
    output logic                    fill_beat,
    output offset_t                 fill_offset,
    output word_t                   fill_data,
    output way_t                    fill_way,
    output logic                    store_hit,
    output way_t                    store_hit_way
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB_ADDR,
        ST_WB_DATA,
        ST_WB_RESP,
        ST_RF_ADDR,
        ST_RF_DATA,
        ST_DONE
    } state_t;

    state_t  state;
    offset_t beat;
    plru_t   plru_mem [1 << `DC_INDEX_BITS];
    plru_t   plru;
    way_t    hit_way;
    way_t    vic_way;
    way_t    acc_way;
    logic    judge;
    logic    hit;
    logic    plru_upd;
    word_t   hit_word;
    word_t   fill_word;

    // tags come out of the ways the cycle after capture
    assign judge = (state == ST_IDLE) & busy;
    assign hit   = |hit_bits;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit_bits[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_word = line_word[hit_way][req_offset];

    assign plru    = plru_mem[rd_index];
    assign vic_way = {plru[0], plru[0] ? plru[2] : plru[1]};

    assign plru_upd = (judge & hit) | (state == ST_DONE);
    assign acc_way  = judge ? hit_way : vic_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < (1 << `DC_INDEX_BITS); s++) begin
                plru_mem[s] <= '0;
            end
        end else if (plru_upd) begin
            plru_mem[rd_index][0] <= ~acc_way[1];   // point root away from w
            if (!acc_way[1]) begin
                plru_mem[rd_index][1] <= ~acc_way[0];
            end else begin
                plru_mem[rd_index][2] <= ~acc_way[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (judge && !hit) begin
                        state <= vic_dirty_bits[vic_way] ? ST_WB_ADDR : ST_RF_ADDR;
                    end
                end
                ST_WB_ADDR: begin
                    if (awready) begin
                        state <= ST_WB_DATA;
                    end
                end
                ST_WB_DATA: begin
                    if (wready) begin
                        beat <= beat + 1'b1;    // wraps back to 0 after beat 3
                        if (wlast) begin
                            state <= ST_WB_RESP;
                        end
                    end
                end
                ST_WB_RESP: begin
                    if (bvalid) begin
                        state <= ST_RF_ADDR;
                    end
                end
                ST_RF_ADDR: begin
                    if (arready) begin
                        state <= ST_RF_DATA;
                    end
                end
                ST_RF_DATA: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            state <= ST_DONE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // requested word merged as it goes into the way
    always_ff @(posedge clk) begin
        if (fill_beat && beat == req_offset) begin
            fill_word <= merge_word(mem_rdata, req_wdata, req_we ? req_wstrb : 4'h0);
        end
    end

    assign awvalid   = (state == ST_WB_ADDR);
    assign wvalid    = (state == ST_WB_DATA);
    assign bready    = (state == ST_WB_RESP);
    assign arvalid   = (state == ST_RF_ADDR);
    assign rready    = (state == ST_RF_DATA);
    assign wlast     = wvalid & (beat == '1);
    assign mem_wdata = line_word[vic_way][beat];
    assign awaddr    = {vic_tag[vic_way], rd_index, {(`DC_WORD_BITS + 2){1'b0}}};
    assign araddr    = {req_tag, rd_index, {(`DC_WORD_BITS + 2){1'b0}}};

    assign fill_beat   = rready & rvalid;
    assign fill_offset = beat;
    assign fill_data   = mem_rdata;
    assign fill_way    = vic_way;

    assign store_hit     = judge & hit & req_we;
    assign store_hit_way = hit_way;

    assign done   = (judge & hit) | (state == ST_DONE);
    assign accept = done;
    assign rdata  = (state == ST_DONE) ? fill_word :
                    req_we ? merge_word(hit_word, req_wdata, req_wstrb) : hit_word;

endmodule

`default_nettype wire

// File: rtl/d_cache_way.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_cache_cfg.svh"

module d_cache_way import d_cache_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire index_t  rd_index,
    input  wire tag_t    req_tag,
    input  wire          wr_en,
    input  wire index_t  wr_index,
    input  wire offset_t wr_offset,
    input  wire word_t   wr_data,
    input  wire strb_t   wr_bstrb,
    input  wire          tag_wr,
    input  wire          dirty_in,
    output logic         hit_bit,
    output logic         vic_dirty,
    output tag_t         vic_tag,
    output word_t        line_word0,
    output word_t        line_word1,
    output word_t        line_word2,
    output word_t        line_word3
);

    localparam int SETS       = 1 << `DC_INDEX_BITS;
    localparam int LINE_WORDS = 1 << `DC_WORD_BITS;

    tag_t            tag_mem [SETS];
    word_t           data_mem [SETS][LINE_WORDS];
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    logic            rd_valid;
    logic            rd_dirty;

    always_ff @(posedge clk) begin
        if (wr_en && tag_wr) begin
            tag_mem[wr_index] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            if (tag_wr) begin
                valid_q[wr_index] <= 1'b1;
                dirty_q[wr_index] <= dirty_in;   // load fill comes in clean
            end else if (dirty_in) begin
                dirty_q[wr_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_bstrb[b]) begin
                    data_mem[wr_index][wr_offset][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_dirty <= 1'b0;
        end else begin
            rd_valid <= valid_q[rd_index];
            rd_dirty <= dirty_q[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        vic_tag    <= tag_mem[rd_index];
        line_word0 <= data_mem[rd_index][0];
        line_word1 <= data_mem[rd_index][1];
        line_word2 <= data_mem[rd_index][2];
        line_word3 <= data_mem[rd_index][3];
    end

    assign hit_bit   = rd_valid & (vic_tag == req_tag);
    assign vic_dirty = rd_valid & rd_dirty;

endmodule

`default_nettype wire

// File: rtl/d_cache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_cache_cfg.svh"

module d_cache_lookup import d_cache_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req,
    input  wire                     we,
    input  wire [`DC_ADDR_BITS-1:0] addr,
    input  wire word_t              wdata,
    input  wire strb_t              wstrb,
    input  wire                     accept,
    input  wire                     fill_beat,
    input  wire offset_t            fill_offset,
    input  wire word_t              fill_data,
    input  wire way_t               fill_way,
    input  wire way_t               store_hit_way,
    input  wire                     store_hit,
    output logic                    busy,
    output index_t                  rd_index,
    output tag_t                    req_tag,
    output offset_t                 req_offset,
    output logic                    req_we,
    output word_t                   req_wdata,
    output strb_t                   req_wstrb,
    output way_mask_t               wr_en,
    output index_t                  wr_index,
    output offset_t                 wr_offset,
    output word_t                   wr_data,
    output strb_t                   wr_bstrb,
    output logic                    tag_wr,
    output logic                    dirty_in
);

    index_t req_index;
    logic   load;

    assign load = req & ~busy;     // first cycle of a held req

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (accept) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_tag    <= addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
            req_index  <= addr[`DC_WORD_BITS+2 +: `DC_INDEX_BITS];
            req_offset <= addr[2 +: `DC_WORD_BITS];
            req_we     <= we;
            req_wdata  <= wdata;
            req_wstrb  <= wstrb;
        end
    end

    // ways index straight off the core address until the request is held
    assign rd_index = busy ? req_index : addr[`DC_WORD_BITS+2 +: `DC_INDEX_BITS];
    assign wr_index = req_index;

    always_comb begin
        wr_en     = '0;
        wr_offset = fill_offset;
        wr_data   = fill_data;
        wr_bstrb  = '1;            // refill beats are full words
        if (store_hit) begin
            wr_en[store_hit_way] = 1'b1;
            wr_offset = req_offset;
            wr_data   = req_wdata;
            wr_bstrb  = req_wstrb;
        end else if (fill_beat) begin
            wr_en[fill_way] = 1'b1;
            // a store miss folds the store bytes into the arriving word
            if (req_we && fill_offset == req_offset) begin
                wr_data = merge_word(fill_data, req_wdata, req_wstrb);
            end
        end
    end

    assign tag_wr   = fill_beat & (fill_offset == '1);  // last refill beat
    assign dirty_in = req_we;

endmodule

`default_nettype wire

// File: rtl/d_cache_pkg.sv
`default_nettype none

`include "d_cache_cfg.svh"

package d_cache_pkg;

    typedef logic [31:0]               word_t;
    typedef logic [3:0]                strb_t;
    typedef logic [`DC_TAG_BITS-1:0]   tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;
    typedef logic [`DC_WORD_BITS-1:0]  offset_t;
    typedef logic [1:0]                way_t;
    typedef logic [`DC_WAYS-1:0]       way_mask_t;
    typedef logic [2:0]                plru_t;     // b0 root, b1 ways 0/1, b2 ways 2/3

    // overlay the enabled bytes of new_w onto old_w
    function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: include/d_cache_cfg.svh
`ifndef D_CACHE_CFG_SVH
`define D_CACHE_CFG_SVH

// byte address width of the core
`define DC_ADDR_BITS  32

// 16 sets
`define DC_INDEX_BITS 4

// 4 words per line
`define DC_WORD_BITS  2

// the plru tree below is built for exactly 4
`define DC_WAYS       4

// what is left above index, word offset and byte offset
`define DC_TAG_BITS   (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_WORD_BITS - 2)

`endif
